// ==== chip_bus.f ====
logic/chip_bus_pkg.sv
logic/dma_regs_pkg.sv
logic/mem_port_if.sv
logic/reg_bus_if.sv
logic/chip_ram.sv
logic/chip_arbiter.sv
logic/cpu_bus_bridge.sv
logic/copy_dma.sv
logic/chip_bus_top.sv
verification/chip_bus_props.sv
verification/chip_bus_tb.sv

// ==== logic/chip_arbiter.sv ====
// chip ram arbiter
// round robin between the cpu bridge and the dma engine onto the one ram port
`timescale 1ns/100ps

module chip_arbiter
	import chip_bus_pkg::*;
(
	input  logic          clk,
	input  logic          reset,
	mem_port_if.arbiter   cpu,
	mem_port_if.arbiter   dma,
	mem_port_if.client    ram
);

	logic cpu_win;
	logic dma_win;
	logic last_dma_q;  // dma took the last grant
	logic own_cpu_q;   // access now at the ram belongs to cpu
	logic own_dma_q;   // ... or to dma

	//------------------------------------------------------------
	// grant, whoever lost last time wins a tie
	//------------------------------------------------------------
	assign cpu_win = cpu.req && (!dma.req || last_dma_q);
	assign dma_win = dma.req && !cpu_win;

	assign cpu.gnt = cpu_win;
	assign dma.gnt = dma_win;

	// winner goes to the ram the same cycle
	assign ram.req   = cpu_win | dma_win;
	assign ram.we    = dma_win ? dma.we    : cpu.we;
	assign ram.addr  = dma_win ? dma.addr  : cpu.addr;
	assign ram.wdata = dma_win ? dma.wdata : cpu.wdata;

	//------------------------------------------------------------
	// response steering
	//------------------------------------------------------------
	assign cpu.ack   = ram.ack & own_cpu_q;
	assign dma.ack   = ram.ack & own_dma_q;
	assign cpu.rdata = ram.rdata;  // qualified by ack at the client
	assign dma.rdata = ram.rdata;

	always_ff @(posedge clk) begin
		if (reset) begin
			last_dma_q <= 1'b0;
			own_cpu_q  <= 1'b0;
			own_dma_q  <= 1'b0;
		end else begin
			own_cpu_q <= cpu_win;  // one cycle record
			own_dma_q <= dma_win;
			if (ram.req)
				last_dma_q <= dma_win;  // only moves on a real grant
		end
	end

endmodule

// ==== logic/chip_bus_pkg.sv ====
// chip bus package
// widths, address map and the cpu word address union
package chip_bus_pkg;

	//------------------------------------------------------------
	// widths
	//------------------------------------------------------------
	localparam int DATA_W   = 16;  // chip ram / register word
	localparam int ADDR_W   = 12;  // cpu word address
	localparam int RAM_AW   = 10;  // 1024 words of chip ram
	localparam int REG_AW   = 3;   // 8 register slots
	localparam int REGION_W = 2;   // top address bits pick the region

	//------------------------------------------------------------
	// address map
	//------------------------------------------------------------
	localparam logic [REGION_W-1:0] REGION_RAM = 2'd0;  // chip ram
	localparam logic [REGION_W-1:0] REGION_REG = 2'd1;  // custom registers
	// regions 2 and 3 unmapped, answer with an error

	typedef logic [DATA_W-1:0] data_t;
	typedef logic [RAM_AW-1:0] ram_addr_t;

	// cpu word address, seen either as a ram index or as a register offset
	typedef union packed {
		struct packed {
			logic [REGION_W-1:0] region;
			ram_addr_t           index;   // word index into chip ram
		} ram;
		struct packed {
			logic [REGION_W-1:0]                 region;
			logic [ADDR_W-REGION_W-REG_AW-1:0]   unused;  // ignored by decode
			logic [REG_AW-1:0]                   offset;  // register slot
		} regs;
	} chip_addr_u;

endpackage

// ==== logic/chip_bus_top.sv ====
// chip bus top
// apb cpu port, copy dma and chip ram around one round robin arbiter
`timescale 1ns/100ps

module chip_bus_top
	import chip_bus_pkg::*;
(
	input  logic              clk,
	input  logic              reset,
	input  logic              psel_i,
	input  logic              penable_i,
	input  logic              pwrite_i,
	input  logic [ADDR_W-1:0] paddr_i,
	input  data_t             pwdata_i,
	output data_t             prdata_o,
	output logic              pready_o,
	output logic              pslverr_o,
	output logic              irq_o       // dma done
);

	mem_port_if cpu_mem ();  // bridge to arbiter
	mem_port_if dma_mem ();  // dma to arbiter
	mem_port_if ram_mem ();  // arbiter to ram
	reg_bus_if  reg_bus ();  // bridge to dma registers

	cpu_bus_bridge bridge_i (
		.clk       (clk),
		.reset     (reset),
		.psel_i    (psel_i),
		.penable_i (penable_i),
		.pwrite_i  (pwrite_i),
		.paddr_i   (paddr_i),
		.pwdata_i  (pwdata_i),
		.prdata_o  (prdata_o),
		.pready_o  (pready_o),
		.pslverr_o (pslverr_o),
		.mem       (cpu_mem.client),
		.regs      (reg_bus.bridge)
	);

	copy_dma dma_i (
		.clk   (clk),
		.reset (reset),
		.regs  (reg_bus.dma),
		.mem   (dma_mem.client),
		.irq_o (irq_o)
	);

	chip_arbiter arb_i (
		.clk   (clk),
		.reset (reset),
		.cpu   (cpu_mem.arbiter),
		.dma   (dma_mem.arbiter),
		.ram   (ram_mem.client)
	);

	chip_ram ram_i (
		.clk (clk),
		.mem (ram_mem.arbiter)
	);

endmodule

// ==== logic/chip_ram.sv ====
// chip ram
// 1024 x 16 single port sync ram, ack and read data one cycle after a request
`timescale 1ns/100ps

module chip_ram
	import chip_bus_pkg::*;
(
	input  logic          clk,
	mem_port_if.arbiter   mem
);

	data_t ram_q [0:(2**RAM_AW)-1];
	data_t rdata_q;
	logic  ack_q;

	assign mem.gnt   = mem.req;  // ram takes an access every cycle
	assign mem.ack   = ack_q;
	assign mem.rdata = rdata_q;

	always_ff @(posedge clk) begin
		if (mem.req && mem.we)
			ram_q[mem.addr] <= mem.wdata;
		if (mem.req && !mem.we)
			rdata_q <= ram_q[mem.addr];  // sync read
		ack_q <= mem.req;                // one pulse per access
	end

endmodule

// ==== logic/copy_dma.sv ====
// copy dma engine
// register block plus a copy/fill sequencer on the chip ram port,
// raises done and an optional irq at the end of a block
`timescale 1ns/100ps

module copy_dma
	import chip_bus_pkg::*;
	import dma_regs_pkg::*;
(
	input  logic          clk,
	input  logic          reset,
	reg_bus_if.dma        regs,
	mem_port_if.client    mem,
	output logic          irq_o
);

	ram_addr_t src_q;
	ram_addr_t dst_q;
	data_t     len_q;
	data_t     fill_q;
	data_t     cnt_q;        // words done so far
	data_t     buf_q;        // word read, waiting to be written
	logic      fill_mode_q;
	logic      irqen_q;
	logic      busy_q;
	logic      done_q;
	logic      wr_phase_q;   // 0 read, 1 write
	logic      pend_q;       // access granted, ack outstanding
	logic      reg_wr;
	logic      start;
	logic      last_word;
	data_t     ctrl_rd;
	data_t     stat_rd;

	assign reg_wr    = regs.wr && !busy_q;  // setup locked while busy
	assign start     = reg_wr && (regs.offset == REG_CTRL) && regs.wdata[CTRL_START];
	assign last_word = (cnt_q + 1'b1) == len_q;
	assign irq_o     = done_q & irqen_q;

	//------------------------------------------------------------
	// memory port
	//------------------------------------------------------------
	assign mem.req   = busy_q && !pend_q;  // one access at a time
	assign mem.we    = wr_phase_q;
	assign mem.addr  = wr_phase_q ? dst_q + cnt_q[RAM_AW-1:0] : src_q + cnt_q[RAM_AW-1:0];
	assign mem.wdata = fill_mode_q ? fill_q : buf_q;

	always_ff @(posedge clk) begin
		if (mem.ack && !wr_phase_q)
			buf_q <= mem.rdata;  // copy read data
	end

	// register read back
	always_comb begin
		ctrl_rd = '0;
		ctrl_rd[CTRL_FILL]  = fill_mode_q;
		ctrl_rd[CTRL_IRQEN] = irqen_q;
		stat_rd = '0;
		stat_rd[STAT_BUSY] = busy_q;
		stat_rd[STAT_DONE] = done_q;
		regs.rdata = '0;
		if (regs.rd) begin
			case (regs.offset)
				REG_CTRL:   regs.rdata = ctrl_rd;
				REG_STATUS: regs.rdata = stat_rd;
				REG_SRC:    regs.rdata = {{(DATA_W-RAM_AW){1'b0}}, src_q};
				REG_DST:    regs.rdata = {{(DATA_W-RAM_AW){1'b0}}, dst_q};
				REG_LEN:    regs.rdata = len_q;
				REG_FILL:   regs.rdata = fill_q;
				default:    regs.rdata = '0;  // 6, 7
			endcase
		end
	end

	//------------------------------------------------------------
	// registers and sequencer
	//------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			src_q       <= '0;
			dst_q       <= '0;
			len_q       <= '0;
			fill_q      <= '0;
			cnt_q       <= '0;
			fill_mode_q <= 1'b0;
			irqen_q     <= 1'b0;
			busy_q      <= 1'b0;
			done_q      <= 1'b0;
			wr_phase_q  <= 1'b0;
			pend_q      <= 1'b0;
		end else begin
			if (reg_wr) begin
				case (regs.offset)
					REG_CTRL: begin
						fill_mode_q <= regs.wdata[CTRL_FILL];
						irqen_q     <= regs.wdata[CTRL_IRQEN];
					end
					REG_SRC:  src_q  <= regs.wdata[RAM_AW-1:0];
					REG_DST:  dst_q  <= regs.wdata[RAM_AW-1:0];
					REG_LEN:  len_q  <= regs.wdata;
					REG_FILL: fill_q <= regs.wdata;
					default:  ;
				endcase
			end
			// done clear allowed any time
			if (regs.wr && (regs.offset == REG_STATUS) && regs.wdata[STAT_DONE])
				done_q <= 1'b0;
			if (start) begin
				cnt_q      <= '0;
				done_q     <= (len_q == '0);  // empty block, done next cycle
				busy_q     <= (len_q != '0);
				wr_phase_q <= regs.wdata[CTRL_FILL];  // fill skips the read
			end else if (busy_q) begin
				if (mem.req && mem.gnt)
					pend_q <= 1'b1;
				if (pend_q && mem.ack) begin
					pend_q <= 1'b0;
					if (!wr_phase_q) begin
						wr_phase_q <= 1'b1;  // word in buf_q, write it next
					end else if (last_word) begin
						busy_q     <= 1'b0;  // busy drops with done rising
						done_q     <= 1'b1;
						wr_phase_q <= 1'b0;
					end else begin
						cnt_q      <= cnt_q + 1'b1;
						wr_phase_q <= fill_mode_q;
					end
				end
			end
		end
	end

endmodule

// ==== logic/cpu_bus_bridge.sv ====
// cpu bus bridge
// apb slave, decodes the region and sends each transfer to chip ram,
// to the dma registers or to an error response
`timescale 1ns/100ps

module cpu_bus_bridge
	import chip_bus_pkg::*;
(
	input  logic              clk,
	input  logic              reset,
	input  logic              psel_i,
	input  logic              penable_i,
	input  logic              pwrite_i,
	input  logic [ADDR_W-1:0] paddr_i,
	input  data_t             pwdata_i,
	output data_t             prdata_o,
	output logic              pready_o,
	output logic              pslverr_o,
	mem_port_if.client        mem,
	reg_bus_if.bridge         regs
);

	chip_addr_u addr;
	logic       access;      // apb access phase
	logic       is_ram;
	logic       is_reg;
	logic       is_err;
	logic       issue;       // first access cycle of a ram transfer
	logic       wait_gnt_q;  // req out, not granted yet
	logic       wait_ack_q;  // granted, data due next cycle

	assign addr   = paddr_i;
	assign access = psel_i & penable_i;

	// region decode, done once
	assign is_ram = (addr.ram.region == REGION_RAM);
	assign is_reg = (addr.regs.region == REGION_REG);
	assign is_err = !is_ram && !is_reg;  // regions 2,3

	//------------------------------------------------------------
	// chip ram side
	//------------------------------------------------------------
	assign issue = access && is_ram && !wait_gnt_q && !wait_ack_q;

	assign mem.req   = issue | wait_gnt_q;  // held while not granted
	assign mem.we    = pwrite_i;            // apb keeps these stable
	assign mem.addr  = addr.ram.index;
	assign mem.wdata = pwdata_i;

	always_ff @(posedge clk) begin
		if (reset) begin
			wait_gnt_q <= 1'b0;
			wait_ack_q <= 1'b0;
		end else begin
			if (mem.req && mem.gnt) begin
				wait_gnt_q <= 1'b0;
				wait_ack_q <= 1'b1;
			end else if (issue) begin
				wait_gnt_q <= 1'b1;  // lost arbitration, keep asking
			end
			if (wait_ack_q && mem.ack)
				wait_ack_q <= 1'b0;  // transfer ends this cycle
		end
	end

	//------------------------------------------------------------
	// register side, straight through
	//------------------------------------------------------------
	assign regs.wr     = access && is_reg && pwrite_i;
	assign regs.rd     = access && is_reg && !pwrite_i;
	assign regs.offset = addr.regs.offset;
	assign regs.wdata  = pwdata_i;

	//------------------------------------------------------------
	// apb response
	//------------------------------------------------------------
	// reg and error finish in the first access cycle, ram on ack
	assign pready_o  = access && (is_reg || is_err || (wait_ack_q && mem.ack));
	assign pslverr_o = access && is_err;

	always_comb begin
		prdata_o = '0;  // unmapped reads return zero
		if (access) begin
			if (is_reg)
				prdata_o = regs.rdata;
			else if (is_ram)
				prdata_o = mem.rdata;
		end
	end

endmodule

// ==== logic/dma_regs_pkg.sv ====
// dma register package
// register offsets and control/status bit positions of the copy engine
package dma_regs_pkg;

	//------------------------------------------------------------
	// register offsets, 6 and 7 read as zero
	//------------------------------------------------------------
	localparam logic [chip_bus_pkg::REG_AW-1:0] REG_CTRL   = 3'd0;
	localparam logic [chip_bus_pkg::REG_AW-1:0] REG_STATUS = 3'd1;
	localparam logic [chip_bus_pkg::REG_AW-1:0] REG_SRC    = 3'd2;  // source word index
	localparam logic [chip_bus_pkg::REG_AW-1:0] REG_DST    = 3'd3;  // destination word index
	localparam logic [chip_bus_pkg::REG_AW-1:0] REG_LEN    = 3'd4;  // word count
	localparam logic [chip_bus_pkg::REG_AW-1:0] REG_FILL   = 3'd5;  // fill pattern

	//------------------------------------------------------------
	// CTRL bits
	//------------------------------------------------------------
	localparam int CTRL_START = 0;  // write 1 to kick, not stored
	localparam int CTRL_FILL  = 1;  // fill mode instead of copy
	localparam int CTRL_IRQEN = 2;  // done raises irq

	//------------------------------------------------------------
	// STATUS bits
	//------------------------------------------------------------
	localparam int STAT_BUSY = 0;  // read only
	localparam int STAT_DONE = 1;  // write 1 to clear

endpackage

// ==== logic/mem_port_if.sv ====
// memory port
// request/grant/ack handshake between a ram client and the arbiter
`timescale 1ns/100ps

interface mem_port_if
	import chip_bus_pkg::*;
();
	logic      req;    // held until gnt
	logic      gnt;    // same cycle as winning req
	logic      we;
	ram_addr_t addr;
	data_t     wdata;
	logic      ack;    // one cycle after gnt
	data_t     rdata;  // valid with ack on reads

	modport client (
		output req, we, addr, wdata,
		input  gnt, ack, rdata
	);

	modport arbiter (
		input  req, we, addr, wdata,
		output gnt, ack, rdata
	);

endinterface

// ==== logic/reg_bus_if.sv ====
// register bus
// single cycle register access from the cpu bridge to the dma block
`timescale 1ns/100ps

interface reg_bus_if
	import chip_bus_pkg::*;
();
	logic              wr;      // write strobe, acted on at the edge
	logic              rd;      // read strobe
	logic [REG_AW-1:0] offset;
	data_t             wdata;
	data_t             rdata;   // combinational return

	modport bridge (
		output wr, rd, offset, wdata,
		input  rdata
	);

	modport dma (
		input  wr, rd, offset, wdata,
		output rdata
	);

endinterface

// ==== verification/chip_bus_input.txt ====
# op addr data, hex: W write, R read and expect data, E unmapped access expecting zero data
# D wait for dma done, data bit 0 is the expected irq_o level
W 000 1234
W 3ff beef
R 000 1234
R 3ff beef
W 402 0100
W 403 0200
W 404 0010
W 405 a5c3
R 402 0100
R 403 0200
R 404 0010
R 405 a5c3
R 406 0000
R 407 0000
E 800 0000
E c04 0000
W 400 0001
D 000 0000
W 403 0280
W 400 0007
D 000 0001
R 400 0006
W 401 0002
R 401 0000
W 404 0000
W 400 0001
D 000 0000
R 280 a5c3
W 403 0300
W 404 0040
W 400 0001
W 402 0155
W 010 cafe
R 402 0100
W 011 f00d
R 010 cafe
R 000 1234
R 011 f00d
D 000 0000
R 402 0100

// ==== verification/chip_bus_props.sv ====
// arbiter checks
// grant exclusivity, ack timing and one outstanding access per client
`timescale 1ns/100ps

module chip_bus_props (
	input logic clk,
	input logic reset,
	input logic cpu_gnt_i,
	input logic cpu_ack_i,
	input logic dma_gnt_i,
	input logic dma_ack_i
);

	int   fail_count = 0;  // polled by the testbench
	logic cpu_out_q;       // cpu granted, ack not seen yet
	logic dma_out_q;

	always_ff @(posedge clk) begin
		if (reset) begin
			cpu_out_q <= 1'b0;
			dma_out_q <= 1'b0;
		end else begin
			cpu_out_q <= cpu_gnt_i | (cpu_out_q & !cpu_ack_i);  // next req may come with ack
			dma_out_q <= dma_gnt_i | (dma_out_q & !dma_ack_i);
		end
	end

	//------------------------------------------------------------
	// grant and ack
	//------------------------------------------------------------
	one_grant: assert property (@(posedge clk) disable iff (reset)
		!(cpu_gnt_i && dma_gnt_i))
		else begin
			$error("both clients granted in one cycle");
			fail_count = fail_count + 1;
		end

	cpu_ack_next: assert property (@(posedge clk) disable iff (reset)
		cpu_gnt_i |=> cpu_ack_i)
		else begin
			$error("cpu ack missing after grant");
			fail_count = fail_count + 1;
		end

	cpu_ack_from_gnt: assert property (@(posedge clk) disable iff (reset)
		cpu_ack_i |-> $past(cpu_gnt_i))
		else begin
			$error("cpu ack without grant");
			fail_count = fail_count + 1;
		end

	dma_ack_next: assert property (@(posedge clk) disable iff (reset)
		dma_gnt_i |=> dma_ack_i)
		else begin
			$error("dma ack missing after grant");
			fail_count = fail_count + 1;
		end

	dma_ack_from_gnt: assert property (@(posedge clk) disable iff (reset)
		dma_ack_i |-> $past(dma_gnt_i))
		else begin
			$error("dma ack without grant");
			fail_count = fail_count + 1;
		end

	// single outstanding access
	cpu_single: assert property (@(posedge clk) disable iff (reset)
		cpu_gnt_i |-> (!cpu_out_q || cpu_ack_i))
		else begin
			$error("cpu has two accesses outstanding");
			fail_count = fail_count + 1;
		end

	dma_single: assert property (@(posedge clk) disable iff (reset)
		dma_gnt_i |-> (!dma_out_q || dma_ack_i))
		else begin
			$error("dma has two accesses outstanding");
			fail_count = fail_count + 1;
		end

endmodule

// ==== verification/chip_bus_tb.sv ====
// chip bus testbench
// file driven apb traffic, ram model kept from the copy/fill rules,
// dma completion polling and a watchdog
`timescale 1ns/100ps

module chip_bus_tb
	import chip_bus_pkg::*;
	import dma_regs_pkg::*;
();

	localparam int CYCLES_PER_LINE  = 200;
	localparam int CYCLES_PER_WORD  = 20;     // preload budget
	localparam int PRELOAD_BASE     = 'h100;
	localparam int PRELOAD_WORDS    = 128;

	logic              clk = 1'b0;
	logic              reset;
	logic              psel;
	logic              penable;
	logic              pwrite;
	logic [ADDR_W-1:0] paddr;
	data_t             pwdata;
	data_t             prdata;
	logic              pready;
	logic              pslverr;
	logic              irq;

	data_t             model [0:(2**RAM_AW)-1];  // expected ram contents
	int                op_q [$];
	logic [ADDR_W-1:0] addr_q [$];
	data_t             data_q [$];
	int                limit_cycles = 0;

	// dma setup as the cpu has programmed it
	ram_addr_t sh_src;
	ram_addr_t sh_dst;
	data_t     sh_len;
	data_t     sh_fill;
	logic      sh_fill_mode;
	logic      sh_busy;     // started and done not yet seen

	always #10 clk = ~clk;  // 20 ns period

	chip_bus_top dut_i (
		.clk       (clk),
		.reset     (reset),
		.psel_i    (psel),
		.penable_i (penable),
		.pwrite_i  (pwrite),
		.paddr_i   (paddr),
		.pwdata_i  (pwdata),
		.prdata_o  (prdata),
		.pready_o  (pready),
		.pslverr_o (pslverr),
		.irq_o     (irq)
	);

	bind chip_arbiter chip_bus_props props_i (
		.clk       (clk),
		.reset     (reset),
		.cpu_gnt_i (cpu.gnt),
		.cpu_ack_i (cpu.ack),
		.dma_gnt_i (dma.gnt),
		.dma_ack_i (dma.ack)
	);

	//------------------------------------------------------------
	// helpers
	//------------------------------------------------------------
	task automatic check_equal(input string what, input logic [31:0] got,
			input logic [31:0] exp);
		if (got !== exp) begin
			$display("MISMATCH at %0t ns: %s, got %h, expected %h", $time, what, got, exp);
			$display("CHECKS FAILED");
			$fatal(1, "stopped at first mismatch");
		end
	endtask

	// address dependent so every word differs
	function automatic data_t preload_word(input logic [ADDR_W-1:0] a);
		logic [31:0] p;
		p = a * 32'd40503;
		return p[15:0] ^ {4'h5, a};
	endfunction

	task automatic idle_gap();
		repeat ($urandom % 4)
			@(negedge clk);
	endtask

	// one apb transfer with outputs sampled at the rising edge
	task automatic apb_transfer(input logic wr, input logic [ADDR_W-1:0] a,
			input data_t wd, output data_t rd, output logic err);
		@(negedge clk);
		psel    <= 1'b1;  // setup
		penable <= 1'b0;
		pwrite  <= wr;
		paddr   <= a;
		pwdata  <= wd;
		@(negedge clk);
		penable <= 1'b1;
		@(posedge clk);
		while (!pready)
			@(posedge clk);  // stalled behind the dma
		rd  = prdata;
		err = pslverr;
		@(negedge clk);
		psel    <= 1'b0;
		penable <= 1'b0;
	endtask

	task automatic ram_readback(input ram_addr_t ix);
		chip_addr_u ca;
		data_t      rd;
		logic       err;
		ca           = '0;
		ca.ram.index = ix;  // region 0
		apb_transfer(1'b0, ca, '0, rd, err);
		check_equal("ram readback error flag", err, 1'b0);
		check_equal($sformatf("ram word %h vs model", ix), rd, model[ix]);
	endtask

	// copy or fill rule applied to the model at the start
	task automatic start_block();
		int        i;
		ram_addr_t s_ix;
		ram_addr_t d_ix;
		sh_busy = (sh_len != '0);
		for (i = 0; i < sh_len; i++) begin
			s_ix = sh_src + ram_addr_t'(i);  // wraps inside ram
			d_ix = sh_dst + ram_addr_t'(i);
			model[d_ix] = sh_fill_mode ? sh_fill : model[s_ix];
		end
	endtask

	task automatic reg_write(input logic [REG_AW-1:0] off, input data_t d);
		if (off == REG_STATUS) begin
			if (d[STAT_DONE])
				check_equal("irq after done clear", irq, 1'b0);
		end else if (!sh_busy) begin  // setup locked while busy
			case (off)
				REG_SRC:  sh_src  = d[RAM_AW-1:0];
				REG_DST:  sh_dst  = d[RAM_AW-1:0];
				REG_LEN:  sh_len  = d;
				REG_FILL: sh_fill = d;
				REG_CTRL: begin
					sh_fill_mode = d[CTRL_FILL];
					if (d[CTRL_START])
						start_block();
				end
				default: ;
			endcase
		end
	endtask

	task automatic write_word(input logic [ADDR_W-1:0] a, input data_t d);
		chip_addr_u ca;
		data_t      rd;
		logic       err;
		ca = a;
		apb_transfer(1'b1, a, d, rd, err);
		if (ca.ram.region == REGION_RAM) begin
			check_equal("ram write error flag", err, 1'b0);
			model[ca.ram.index] = d;
		end else if (ca.regs.region == REGION_REG) begin
			check_equal("register write error flag", err, 1'b0);
			reg_write(ca.regs.offset, d);
		end else begin
			check_equal("unmapped write error flag", err, 1'b1);
		end
	endtask

	task automatic read_compare(input logic [ADDR_W-1:0] a, input data_t exp);
		chip_addr_u ca;
		data_t      rd;
		logic       err;
		ca = a;
		apb_transfer(1'b0, a, '0, rd, err);
		check_equal($sformatf("read %h error flag", a), err, 1'b0);
		check_equal($sformatf("read %h vs file", a), rd, exp);
		if (ca.ram.region == REGION_RAM)
			check_equal($sformatf("read %h vs model", a), rd, model[ca.ram.index]);
	endtask

	task automatic unmapped_access(input logic [ADDR_W-1:0] a, input data_t exp);
		data_t rd;
		logic  err;
		apb_transfer(1'b0, a, 16'hffff, rd, err);
		check_equal("unmapped pslverr", err, 1'b1);
		check_equal("unmapped read data", rd, exp);
	endtask

	// poll status then read back the block against the model
	task automatic wait_done(input logic exp_irq);
		chip_addr_u ca;
		data_t      st;
		logic       err;
		int         i;
		ca             = '0;
		ca.regs.region = REGION_REG;
		ca.regs.offset = REG_STATUS;
		st             = '0;
		while (!st[STAT_DONE]) begin
			idle_gap();
			apb_transfer(1'b0, ca, '0, st, err);
			check_equal("status read error flag", err, 1'b0);
		end
		check_equal("busy low with done", st[STAT_BUSY], 1'b0);
		check_equal("irq at done", irq, exp_irq);
		sh_busy = 1'b0;
		for (i = 0; i < sh_len; i++) begin
			ram_readback(sh_dst + ram_addr_t'(i));
			if (!sh_fill_mode)
				ram_readback(sh_src + ram_addr_t'(i));  // source untouched
		end
	endtask

	task automatic load_stimulus();
		int                fd;
		int                n;
		int                opc;
		string             line;
		logic [ADDR_W-1:0] a;
		data_t             d;
		fd = $fopen("verification/chip_bus_input.txt", "r");
		if (fd == 0) begin
			$display("cannot open the stimulus file");
			$display("CHECKS FAILED");
			$fatal(1, "no stimulus");
		end else begin
			while ($fgets(line, fd) > 0) begin
				if (line.len() < 2 || line.getc(0) == "#")
					continue;  // blank or comment
				n = $sscanf(line, "%c %h %h", opc, a, d);
				if (n != 3 || !(opc == "W" || opc == "R" || opc == "E" || opc == "D")) begin
					$display("stimulus line not understood: %s", line);
					$display("CHECKS FAILED");
					$fatal(1, "bad stimulus");
				end else begin
					op_q.push_back(opc);
					addr_q.push_back(a);
					data_q.push_back(d);
				end
			end
			$fclose(fd);
		end
	endtask

	//------------------------------------------------------------
	// main sequence
	//------------------------------------------------------------
	initial begin
		int i;
		void'($urandom(88));
		reset        = 1'b1;
		psel         = 1'b0;
		penable      = 1'b0;
		pwrite       = 1'b0;
		paddr        = '0;
		pwdata       = '0;
		sh_src       = '0;
		sh_dst       = '0;
		sh_len       = '0;
		sh_fill      = '0;
		sh_fill_mode = 1'b0;
		sh_busy      = 1'b0;
		load_stimulus();
		limit_cycles = 16 + op_q.size() * CYCLES_PER_LINE + PRELOAD_WORDS * CYCLES_PER_WORD;
		repeat (16) @(posedge clk);
		@(negedge clk);
		reset <= 1'b0;
		check_equal("pready after reset", pready, 1'b0);
		check_equal("pslverr after reset", pslverr, 1'b0);
		check_equal("irq after reset", irq, 1'b0);
		for (i = 0; i < PRELOAD_WORDS; i++)
			write_word(ADDR_W'(PRELOAD_BASE + i), preload_word(ADDR_W'(PRELOAD_BASE + i)));
		for (i = 0; i < op_q.size(); i++) begin
			idle_gap();
			case (op_q[i])
				"W": write_word(addr_q[i], data_q[i]);
				"R": read_compare(addr_q[i], data_q[i]);
				"E": unmapped_access(addr_q[i], data_q[i]);
				default: wait_done(data_q[i][0]);
			endcase
		end
		repeat (2) @(negedge clk);
		if (dut_i.arb_i.props_i.fail_count == 0) begin
			$display("ALL CHECKS PASSED");
			$finish;
		end else begin
			$display("CHECKS FAILED");
			$fatal(1, "arbiter assertions failed");
		end
	end

	// stop soon after an arbiter assertion fires
	always @(negedge clk) begin
		if (dut_i.arb_i.props_i.fail_count != 0) begin
			$display("an arbiter assertion failed");
			$display("CHECKS FAILED");
			$fatal(1, "assertion failure");
		end
	end

	// watchdog
	initial begin
		wait (limit_cycles > 0);
		repeat (limit_cycles) @(posedge clk);
		$display("timeout, the run did not finish within %0d cycles", limit_cycles);
		$display("CHECKS FAILED");
		$fatal(1, "watchdog expired");
	end

endmodule
